/* Makefile */
# Verilator build and run of the pattern path testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILE_LIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/control_regs.sv */
module control_regs (
	input  logic                          clk_usb,
	input  logic                          reset_i,
	input  usb_host_pkg::usb_cmd_t        cmd_i,
	output dmd_pattern_pkg::pattern_cfg_t cfg_o
);
	import usb_host_pkg::*;
	import dmd_pattern_pkg::*;

	usb_word_t      pending_q;
	logic           load_reset_q;
	logic           load_enable_q;
	pattern_index_t last_pattern_q;

	// ***********************************************************************
	// pending data
	// ***********************************************************************

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			pending_q <= '0;
		end else if (cmd_i.kind == CMD_REG_DATA) begin
			pending_q <= cmd_i.word;
		end
	end

	// ***********************************************************************
	// commit on address write
	// ***********************************************************************

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			load_reset_q   <= 1'b0;
			load_enable_q  <= 1'b0;
			last_pattern_q <= '0;
		end else if (cmd_i.kind == CMD_REG_ADDR) begin
			case (cmd_i.word)
				// any nonzero value holds the load positions cleared
				REG_LOAD_RESET: load_reset_q <= (pending_q != '0);
				REG_LAST_PATTERN: begin
					last_pattern_q <= pending_q[$bits(pattern_index_t)-1:0];
				end
				REG_LOAD_ENABLE: load_enable_q <= pending_q[0];
				// unknown addresses are ignored
				default: begin
				end
			endcase
		end
	end

	assign cfg_o.load_reset   = load_reset_q;
	assign cfg_o.load_enable  = load_enable_q;
	assign cfg_o.last_pattern = last_pattern_q;

endmodule

/* design/dmd_pattern_pkg.sv */
package dmd_pattern_pkg;

	// ***********************************************************************
	// pattern geometry
	// ***********************************************************************

	// rows of 16 pixels per pattern
	localparam int PATTERN_WORDS = 16;
	localparam int MAX_PATTERNS  = 4;

	typedef logic [$clog2(PATTERN_WORDS)-1:0] row_index_t;
	typedef logic [$clog2(MAX_PATTERNS)-1:0]  pattern_index_t;

	// pattern index in the upper bits, so the struct is also the flat address
	typedef struct packed {
		pattern_index_t pattern;
		row_index_t     row;
	} pat_addr_t;

	// ***********************************************************************
	// configuration and memory write
	// ***********************************************************************

	typedef struct packed {
		logic           load_reset;
		logic           load_enable;
		pattern_index_t last_pattern;
	} pattern_cfg_t;

	typedef struct packed {
		logic                    we;
		pat_addr_t               addr;
		usb_host_pkg::usb_word_t data;
	} pat_write_t;

endpackage

/* design/pattern_loader.sv */
module pattern_loader (
	input  logic                          clk_usb,
	input  logic                          reset_i,
	input  usb_host_pkg::usb_cmd_t        cmd_i,
	input  dmd_pattern_pkg::pattern_cfg_t cfg_i,
	output dmd_pattern_pkg::pat_write_t   wr_o,
	output logic                          load_done_o
);
	import usb_host_pkg::*;
	import dmd_pattern_pkg::*;

	pat_addr_t pos_q;
	logic      load_done_q;
	logic      we_q;
	pat_addr_t wr_addr_q;
	usb_word_t wr_data_q;
	logic      accept;
	logic      last_row;

	// words outside a load window are dropped
	assign accept = (cmd_i.kind == CMD_PATTERN_WORD) && cfg_i.load_enable &&
		!cfg_i.load_reset && !load_done_q;
	assign last_row = (pos_q.row == row_index_t'(PATTERN_WORDS - 1));

	always_ff @(posedge clk_usb) begin
		if (reset_i || cfg_i.load_reset) begin
			pos_q       <= '0;
			load_done_q <= 1'b0;
			we_q        <= 1'b0;
		end else begin
			we_q <= accept;
			if (accept) begin
				if (last_row) begin
					pos_q.row     <= '0;
					pos_q.pattern <= pos_q.pattern + 1'b1;
					load_done_q   <= (pos_q.pattern == cfg_i.last_pattern);
				end else begin
					pos_q.row <= pos_q.row + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_usb) begin
		if (accept) begin
			wr_addr_q <= pos_q;
			wr_data_q <= cmd_i.word;
		end
	end

	assign wr_o.we      = we_q;
	assign wr_o.addr    = wr_addr_q;
	assign wr_o.data    = wr_data_q;
	assign load_done_o  = load_done_q;

	// writes stay inside the configured pattern range
	a_write_in_range: assert property (
		@(posedge clk_usb) disable iff (reset_i)
		wr_o.we |-> (wr_o.addr.pattern <= cfg_i.last_pattern)
	);

endmodule

/* design/pattern_sequencer.sv */
module pattern_sequencer (
	input  logic                          clk_usb,
	input  logic                          reset_i,
	input  logic                          trigger_i,
	input  dmd_pattern_pkg::pattern_cfg_t cfg_i,
	input  logic                          load_done_i,
	output dmd_pattern_pkg::pat_addr_t    rd_addr_o,
	input  usb_host_pkg::usb_word_t       rd_data_i,
	output usb_host_pkg::usb_word_t       dout_o,
	output logic                          dvalid_o
);
	import usb_host_pkg::*;
	import dmd_pattern_pkg::*;

	logic           trig_s_q;
	logic           trig_d_q;
	logic           active_q;
	row_index_t     row_q;
	pattern_index_t disp_pat_q;
	logic           rd_valid_q;
	logic           dvalid_q;
	usb_word_t      dout_q;
	logic           busy;
	logic           start;

	// ***********************************************************************
	// trigger edge and readout start
	// ***********************************************************************

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			trig_s_q <= 1'b0;
			trig_d_q <= 1'b0;
		end else begin
			trig_s_q <= trigger_i;
			trig_d_q <= trig_s_q;
		end
	end

	// busy until the last word has left the output register
	assign busy  = active_q || rd_valid_q || dvalid_q;
	assign start = trig_s_q && !trig_d_q && !busy && !cfg_i.load_enable && load_done_i;

	// ***********************************************************************
	// row walk through the display pattern
	// ***********************************************************************

	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			active_q   <= 1'b0;
			row_q      <= '0;
			disp_pat_q <= '0;
		end else begin
			if (start) begin
				active_q <= 1'b1;
				row_q    <= '0;
			end else if (active_q) begin
				row_q <= row_q + 1'b1;
				if (row_q == row_index_t'(PATTERN_WORDS - 1)) begin
					active_q <= 1'b0;
					// next readout takes the next pattern, wrapping after the last
					if (disp_pat_q == cfg_i.last_pattern) begin
						disp_pat_q <= '0;
					end else begin
						disp_pat_q <= disp_pat_q + 1'b1;
					end
				end
			end
			if (cfg_i.load_reset) begin
				disp_pat_q <= '0;
			end
		end
	end

	assign rd_addr_o.pattern = disp_pat_q;
	assign rd_addr_o.row     = row_q;

	// valid follows the memory latency, then the output register
	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			rd_valid_q <= 1'b0;
			dvalid_q   <= 1'b0;
		end else begin
			rd_valid_q <= active_q;
			dvalid_q   <= rd_valid_q;
		end
	end

	always_ff @(posedge clk_usb) begin
		dout_q <= rd_data_i;
	end

	assign dout_o   = dout_q;
	assign dvalid_o = dvalid_q;

	// each burst is one pattern long and followed by a gap
	a_burst_length: assert property (
		@(posedge clk_usb) disable iff (reset_i)
		$rose(dvalid_q) |-> ##PATTERN_WORDS !dvalid_q
	);

endmodule

/* design/pattern_store.sv */
module pattern_store (
	input  logic                        clk_usb,
	input  dmd_pattern_pkg::pat_write_t wr_i,
	input  dmd_pattern_pkg::pat_addr_t  rd_addr_i,
	output usb_host_pkg::usb_word_t     rd_data_o
);
	import usb_host_pkg::*;
	import dmd_pattern_pkg::*;

	// pattern-major layout, pat_addr_t doubles as the flat index
	usb_word_t mem [MAX_PATTERNS*PATTERN_WORDS];
	usb_word_t rd_data_q;

	// write port
	always_ff @(posedge clk_usb) begin
		if (wr_i.we) begin
			mem[wr_i.addr] <= wr_i.data;
		end
	end

	// read port, one cycle of latency
	always_ff @(posedge clk_usb) begin
		rd_data_q <= mem[rd_addr_i];
	end

	assign rd_data_o = rd_data_q;

endmodule

/* design/pattern_top.sv */
module pattern_top (
	input  logic                    clk_usb,
	input  logic                    reset_i,
	input  usb_host_pkg::usb_ctl_t  ctl_i,
	input  usb_host_pkg::usb_word_t usb_data_i,
	input  logic                    trigger_i,
	output usb_host_pkg::usb_word_t dout_o,
	output logic                    dvalid_o,
	output logic                    load_done_o
);
	import usb_host_pkg::*;
	import dmd_pattern_pkg::*;

	usb_cmd_t     cmd;
	pattern_cfg_t cfg;
	pat_write_t   wr;
	pat_addr_t    rd_addr;
	usb_word_t    rd_data;

	// ***********************************************************************
	// host side, bus decode to memory writes
	// ***********************************************************************

	usb_port_decoder u_decoder (
		.clk_usb    (clk_usb),
		.reset_i    (reset_i),
		.ctl_i      (ctl_i),
		.usb_data_i (usb_data_i),
		.cmd_o      (cmd)
	);

	control_regs u_regs (
		.clk_usb (clk_usb),
		.reset_i (reset_i),
		.cmd_i   (cmd),
		.cfg_o   (cfg)
	);

	pattern_loader u_loader (
		.clk_usb     (clk_usb),
		.reset_i     (reset_i),
		.cmd_i       (cmd),
		.cfg_i       (cfg),
		.wr_o        (wr),
		.load_done_o (load_done_o)
	);

	// ***********************************************************************
	// storage and display side
	// ***********************************************************************

	pattern_store u_store (
		.clk_usb   (clk_usb),
		.wr_i      (wr),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	pattern_sequencer u_sequencer (
		.clk_usb     (clk_usb),
		.reset_i     (reset_i),
		.trigger_i   (trigger_i),
		.cfg_i       (cfg),
		.load_done_i (load_done_o),
		.rd_addr_o   (rd_addr),
		.rd_data_i   (rd_data),
		.dout_o      (dout_o),
		.dvalid_o    (dvalid_o)
	);

endmodule

/* design/usb_host_pkg.sv */
package usb_host_pkg;

	// one word on the 16-bit slave bus
	typedef logic [15:0] usb_word_t;

	// ctl0 is the msb when a strobe pattern is written as a literal
	typedef struct packed {
		logic ctl0;
		logic ctl1;
		logic ctl2;
	} usb_ctl_t;

	typedef enum logic [1:0] {
		CMD_NONE,
		CMD_REG_DATA,
		CMD_REG_ADDR,
		CMD_PATTERN_WORD
	} cmd_kind_t;

	typedef struct packed {
		cmd_kind_t kind;
		usb_word_t word;
	} usb_cmd_t;

	// strobe patterns driven by the host
	localparam usb_ctl_t CTL_REG_DATA = 3'b010;
	localparam usb_ctl_t CTL_REG_ADDR = 3'b110;
	localparam usb_ctl_t CTL_PATTERN  = 3'b011;

	// register map, matched against the whole bus word
	localparam usb_word_t REG_LAST_PATTERN = 16'd30;
	localparam usb_word_t REG_LOAD_RESET   = 16'd31;
	localparam usb_word_t REG_LOAD_ENABLE  = 16'd32;

endpackage

/* design/usb_port_decoder.sv */
module usb_port_decoder (
	input  logic                    clk_usb,
	input  logic                    reset_i,
	input  usb_host_pkg::usb_ctl_t  ctl_i,
	input  usb_host_pkg::usb_word_t usb_data_i,
	output usb_host_pkg::usb_cmd_t  cmd_o
);
	import usb_host_pkg::*;

	cmd_kind_t kind_q;
	usb_word_t word_q;

	// classify the strobes seen at this edge
	always_ff @(posedge clk_usb) begin
		if (reset_i) begin
			kind_q <= CMD_NONE;
		end else begin
			case (ctl_i)
				CTL_REG_DATA: kind_q <= CMD_REG_DATA;
				CTL_REG_ADDR: kind_q <= CMD_REG_ADDR;
				CTL_PATTERN:  kind_q <= CMD_PATTERN_WORD;
				default:      kind_q <= CMD_NONE;
			endcase
		end
	end

	// bus word captured every cycle, only meaningful with a command kind
	always_ff @(posedge clk_usb) begin
		word_q <= usb_data_i;
	end

	assign cmd_o.kind = kind_q;
	assign cmd_o.word = word_q;

	// a pattern word must come from the ctl1+ctl2 strobe one cycle earlier
	a_pattern_from_strobe: assert property (
		@(posedge clk_usb) disable iff (reset_i)
		(cmd_o.kind == CMD_PATTERN_WORD) |-> ($past(ctl_i) == CTL_PATTERN)
	);

endmodule

/* sources.f */
design/usb_host_pkg.sv
design/dmd_pattern_pkg.sv
design/usb_port_decoder.sv
design/control_regs.sv
design/pattern_loader.sv
design/pattern_store.sv
design/pattern_sequencer.sv
design/pattern_top.sv
test/tb_checker.sv
test/tb_top.sv

/* test/pattern_trace.txt */
# R <reg addr, dec> <data, hex>   P <first word, hex> <count, dec>   T trigger pulse
# W <idle cycles, dec>   E <first expected word, hex> <count, dec>, words run first, first+1, ...
T
W 4
R 30 2
R 32 1
P 1000 16
T
P 2000 16
P 3000 16
W 5
T
W 25
R 32 0
W 4
T
W 25
E 1000 16
T
W 25
E 2000 16
T
W 25
E 3000 16
T
W 25
E 1000 16
T
W 5
T
W 25
E 2000 16
T
W 25
E 3000 16
P 7000 16
W 4
T
W 25
E 1000 16
R 31 1
R 31 0
R 32 1
P 4000 16
P 5000 16
P 6000 16
W 5
R 32 0
W 4
T
W 25
E 4000 16
T
W 25
E 5000 16

/* test/tb_checker.sv */
module tb_checker (
	input  logic                    clk_usb,
	input  usb_host_pkg::usb_word_t dout_i,
	input  logic                    dvalid_i,
	input  logic                    load_done_i,
	input  logic                    done_check_i,
	input  logic                    done_expected_i,
	input  logic                    end_i,
	output int                      error_count_o,
	output int                      checked_count_o
);
	timeunit 1ns;
	timeprecision 100ps;

	import usb_host_pkg::*;

	localparam string TRACE_FILE = "test/pattern_trace.txt";

	usb_word_t expected[$];
	int        mismatch_count = 0;
	int        extra_count    = 0;
	int        missing_count  = 0;
	int        format_count   = 0;
	int        done_count     = 0;
	int        checked_count  = 0;

	// expand each E line into a run of consecutive words
	initial begin
		int        fd;
		int        fields;
		int        count;
		string     line;
		usb_word_t word;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("checker cannot open trace file %s", TRACE_FILE);
			format_count++;
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.getc(0) == "E") begin
					fields = $sscanf(line, "E %h %d", word, count);
					if (fields == 2) begin
						repeat (count) begin
							expected.push_back(word);
							word = word + 16'd1;
						end
					end else begin
						$display("checker cannot read trace line: %s", line);
						format_count++;
					end
				end
			end
			$fclose(fd);
		end
	end

	// outputs settled well before the falling edge
	always @(negedge clk_usb) begin
		usb_word_t want;
		if (dvalid_i) begin
			if (expected.size() == 0) begin
				$display("** Error at %0t ns: word %h on dout_o but none was expected",
					$time, dout_i);
				extra_count++;
			end else begin
				want = expected.pop_front();
				checked_count++;
				if (dout_i !== want) begin
					$display("** Error at %0t ns: dout_o expected %h, seen %h",
						$time, want, dout_i);
					mismatch_count++;
				end
			end
		end
		if (done_check_i && load_done_i !== done_expected_i) begin
			$display("** Error at %0t ns: load_done_o expected %b, seen %b",
				$time, done_expected_i, load_done_i);
			done_count++;
		end
	end

	always @(posedge end_i) begin
		if (expected.size() != 0) begin
			$display("%0d expected words never appeared on dout_o", expected.size());
			missing_count = expected.size();
		end
	end

	assign error_count_o   = mismatch_count + extra_count + missing_count + format_count +
		done_count;
	assign checked_count_o = checked_count;

endmodule

/* test/tb_top.sv */
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	import usb_host_pkg::*;

	localparam int    RESET_CYCLES    = 10;
	localparam int    CYCLES_PER_LINE = 200;
	localparam int    DRAIN_CYCLES    = 30;
	localparam string TRACE_FILE      = "test/pattern_trace.txt";

	logic      clk_usb;
	logic      reset_i;
	usb_ctl_t  ctl_i;
	usb_word_t usb_data_i;
	logic      trigger_i;
	usb_word_t dout_o;
	logic      dvalid_o;
	logic      load_done_o;

	logic  check_end;
	logic  trace_loaded;
	int    checker_errors;
	int    checked_words;
	int    trace_errors;
	string lines[$];

	// register state and load progress as the host sees them
	logic  exp_load_enable;
	logic  exp_load_reset;
	int    exp_last_pattern;
	int    accepted_words;
	logic  done_expected;
	logic  done_check;

	// 10 ns clock
	initial clk_usb = 1'b0;
	always #5 clk_usb = ~clk_usb;

	pattern_top pattern_top_i (
		.clk_usb     (clk_usb),
		.reset_i     (reset_i),
		.ctl_i       (ctl_i),
		.usb_data_i  (usb_data_i),
		.trigger_i   (trigger_i),
		.dout_o      (dout_o),
		.dvalid_o    (dvalid_o),
		.load_done_o (load_done_o)
	);

	tb_checker tb_checker_i (
		.clk_usb         (clk_usb),
		.dout_i          (dout_o),
		.dvalid_i        (dvalid_o),
		.load_done_i     (load_done_o),
		.done_check_i    (done_check),
		.done_expected_i (done_expected),
		.end_i           (check_end),
		.error_count_o   (checker_errors),
		.checked_count_o (checked_words)
	);

	// ***********************************************************************
	// bus and trigger drivers
	// ***********************************************************************

	// inputs change 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk_usb);
		#1;
	endtask

	task automatic drive_bus(input logic c0, input logic c1, input logic c2,
		input usb_word_t word);
		ctl_i.ctl0 = c0;
		ctl_i.ctl1 = c1;
		ctl_i.ctl2 = c2;
		usb_data_i = word;
		next_cycle();
	endtask

	// data strobe first, then the address strobe commits it
	task automatic write_register(input usb_word_t addr, input usb_word_t data);
		drive_bus(1'b0, 1'b1, 1'b0, data);
		drive_bus(1'b1, 1'b1, 1'b0, addr);
		drive_bus(1'b0, 1'b0, 1'b0, '0);
	endtask

	task automatic send_pattern_words(input usb_word_t first, input int count);
		usb_word_t word;
		word = first;
		repeat (count) begin
			drive_bus(1'b0, 1'b1, 1'b1, word);
			word = word + 16'd1;
		end
		drive_bus(1'b0, 1'b0, 1'b0, '0);
	endtask

	// load_done_o is compared while the trigger is high
	task automatic pulse_trigger();
		trigger_i  = 1'b1;
		done_check = 1'b1;
		next_cycle();
		trigger_i  = 1'b0;
		done_check = 1'b0;
		next_cycle();
	endtask

	// ***********************************************************************
	// expected load state
	// ***********************************************************************

	task automatic update_expected_regs(input usb_word_t addr, input usb_word_t data);
		case (addr)
			REG_LOAD_RESET: begin
				exp_load_reset = (data != '0);
				if (exp_load_reset) begin
					accepted_words = 0;
					done_expected  = 1'b0;
				end
			end
			REG_LAST_PATTERN: exp_last_pattern = int'(data[1:0]);
			REG_LOAD_ENABLE:  exp_load_enable = data[0];
			default: begin
			end
		endcase
	endtask

	// loading ends with the last row of the last pattern
	task automatic count_accepted_words(input int count);
		repeat (count) begin
			if (exp_load_enable && !exp_load_reset && !done_expected) begin
				accepted_words++;
				if (accepted_words ==
					(exp_last_pattern + 1) * dmd_pattern_pkg::PATTERN_WORDS) begin
					done_expected = 1'b1;
				end
			end
		end
	endtask

	task automatic bad_line(input string line);
		$display("trace line not understood: %s", line);
		trace_errors++;
	endtask

	task automatic run_line(input string line);
		usb_word_t addr;
		usb_word_t word;
		int        count;
		int        fields;
		case (line.getc(0))
			"R": begin
				fields = $sscanf(line, "R %d %h", addr, word);
				if (fields == 2) begin
					write_register(addr, word);
					update_expected_regs(addr, word);
				end else begin
					bad_line(line);
				end
			end
			"P": begin
				fields = $sscanf(line, "P %h %d", word, count);
				if (fields == 2) begin
					send_pattern_words(word, count);
					count_accepted_words(count);
				end else begin
					bad_line(line);
				end
			end
			"T": pulse_trigger();
			"W": begin
				fields = $sscanf(line, "W %d", count);
				if (fields == 1) repeat (count) next_cycle();
				else bad_line(line);
			end
			// expected words belong to the checker
			"E", "#", "\n", 8'd0: begin
			end
			default: bad_line(line);
		endcase
	endtask

	// ***********************************************************************
	// main sequence
	// ***********************************************************************

	initial begin
		int    fd;
		string line;
		reset_i          = 1'b1;
		ctl_i            = '0;
		usb_data_i       = '0;
		trigger_i        = 1'b0;
		check_end        = 1'b0;
		trace_loaded     = 1'b0;
		trace_errors     = 0;
		exp_load_enable  = 1'b0;
		exp_load_reset   = 1'b0;
		exp_last_pattern = 0;
		accepted_words   = 0;
		done_expected    = 1'b0;
		done_check       = 1'b0;
		fd = $fopen(TRACE_FILE, "r");
		if (fd == 0) begin
			$display("cannot open trace file %s", TRACE_FILE);
			trace_errors++;
		end else begin
			while ($fgets(line, fd) != 0) lines.push_back(line);
			$fclose(fd);
		end
		trace_loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_usb);
		#1;
		reset_i = 1'b0;
		foreach (lines[i]) run_line(lines[i]);
		repeat (DRAIN_CYCLES) next_cycle();
		check_end = 1'b1;
		#1;
		$display("words checked: %0d, checker errors: %0d, trace errors: %0d",
			checked_words, checker_errors, trace_errors);
		if (checker_errors == 0 && trace_errors == 0 && checked_words > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// budget grows with the trace length
	initial begin
		wait (trace_loaded);
		repeat (lines.size() * CYCLES_PER_LINE + RESET_CYCLES + DRAIN_CYCLES) begin
			@(posedge clk_usb);
		end
		$display("watchdog expired, the trace did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule
